// ==== compile.f ====
bus_pkg.sv
periph_pkg.sv
bus_slice.sv
target_router.sv
boot_ram.sv
cycle_counter.sv
pad_reader.sv
soc_bus_top.sv
soc_bus_props.sv
tb_soc_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bus fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_bus \
	-f compile.f --Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

# Keep running past assertion errors so the bench can report them
./obj_dir/sim_tb +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Verification passed$" "$log"; then
	exit 0
fi
echo "Pass line not found in $log"
exit 1

// ==== tb_soc_bus.sv ====
// SoC bus fabric testbench
`timescale 1ns/100ps

module tb_soc_bus;

	localparam int clk_period = 20;
	localparam int mix_count = 64;
	localparam int cnt_reads = 4;
	localparam int txn_count = periph_pkg::boot_depth + 2 * mix_count + cnt_reads + 6;
	// One scan is 18 ticks
	localparam int scan_clocks = 18 << periph_pkg::pad_div_bits;
	localparam int limit_cycles = 8 * txn_count + 3 * scan_clocks + 200;

	logic        clk_50mhz = 1'b0;
	logic        resetn;
	logic        req_valid;
	logic        req_ready;
	logic        req_write;
	logic [31:0] req_addr;
	logic [31:0] req_wdata;
	logic [3:0]  req_strb;
	logic        rsp_valid;
	logic        rsp_ready = 1'b1;
	logic [31:0] rsp_rdata;
	logic [1:0]  rsp_resp;
	logic        pad_clk;
	logic        pad_latch;
	logic [7:0]  pad0_buttons = '0;
	logic [7:0]  pad1_buttons = '0;
	logic [7:0]  pad0_shift = '0;
	logic [7:0]  pad1_shift = '0;
	logic [15:0] data_lfsr = 16'd19919;
	logic [15:0] stall_lfsr = 16'd19919;
	logic        stall_bit;
	logic [31:0] model_mem [periph_pkg::boot_depth];
	logic [7:0]  ram_used [$];
	logic [31:0] exp_data [$];
	logic [1:0]  exp_resp [$];
	logic        exp_counter [$];
	logic [31:0] last_cnt_low = '0;
	int          errors = 0;

	soc_bus_top soc_bus_top_i (
		.clk_50mhz(clk_50mhz), .resetn(resetn),
		.req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
		.req_addr(req_addr), .req_wdata(req_wdata), .req_strb(req_strb),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata),
		.rsp_resp(rsp_resp), .pad_clk(pad_clk), .pad_latch(pad_latch),
		.pad0_data(~pad0_shift[0]), .pad1_data(~pad1_shift[0])
	);

	always #(clk_period / 2) clk_50mhz = ~clk_50mhz;

	// Game pads drive active-low data with bit 0 first
	always @(posedge pad_clk or posedge pad_latch) begin
		if (pad_latch) begin
			pad0_shift <= pad0_buttons;
			pad1_shift <= pad1_buttons;
		end else begin
			pad0_shift <= pad0_shift >> 1;
			pad1_shift <= pad1_shift >> 1;
		end
	end

	// Galois form of x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function logic [31:0] take_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v[i] = data_lfsr[0];
			data_lfsr = lfsr_step(data_lfsr);
		end
		return v;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, wdata,
		input logic [3:0] strb);
		logic [31:0] m;
		int          b;
		m = old;
		for (b = 0; b < 4; b++)
			if (strb[b])
				m[8*b +: 8] = wdata[8*b +: 8];
		return m;
	endfunction

	// Ready about three cycles in four
	always @(negedge clk_50mhz) begin
		stall_bit = stall_lfsr[0];
		stall_lfsr = lfsr_step(stall_lfsr);
		rsp_ready = stall_bit | stall_lfsr[0];
		stall_lfsr = lfsr_step(stall_lfsr);
	end

	task automatic check_reset_outputs();
		assert (!req_ready && !rsp_valid && !pad_latch && !pad_clk) else begin
			errors++;
			$display("FAILED at time %0t: in reset req_ready %b rsp_valid %b latch %b clk %b",
				$time, req_ready, rsp_valid, pad_latch, pad_clk);
		end
	endtask

	task automatic send(input logic write, input logic [31:0] addr, wdata,
		input logic [3:0] strb, input logic [31:0] rdata, input logic [1:0] resp,
		input logic counter);
		req_valid = 1'b1;
		req_write = write;
		req_addr = addr;
		req_wdata = wdata;
		req_strb = strb;
		exp_data.push_back(rdata);
		exp_resp.push_back(resp);
		exp_counter.push_back(counter);
		while (!req_ready)
			@(negedge clk_50mhz);
		@(negedge clk_50mhz);
		req_valid = 1'b0;
	endtask

	task automatic check_response();
		logic [31:0] data;
		logic [1:0]  resp;
		logic        counter;
		if (exp_resp.size() == 0) begin
			errors++;
			$display("Response at time %0t arrived with no request outstanding", $time);
		end else begin
			data = exp_data.pop_front();
			resp = exp_resp.pop_front();
			counter = exp_counter.pop_front();
			assert (rsp_resp == resp) else begin
				errors++;
				$display("FAILED at time %0t: resp %0d, expected %0d", $time, rsp_resp, resp);
			end
			if (counter) begin
				assert (rsp_rdata > last_cnt_low) else begin
					errors++;
					$display("FAILED at time %0t: counter %0h not above %0h",
						$time, rsp_rdata, last_cnt_low);
				end
				last_cnt_low = rsp_rdata;
			end else begin
				assert (rsp_rdata == data) else begin
					errors++;
					$display("FAILED at time %0t: rdata %h, expected %h", $time, rsp_rdata, data);
				end
			end
		end
	endtask

	always @(posedge clk_50mhz) begin
		if (resetn && rsp_valid && rsp_ready)
			check_response();
	end

	initial begin
		int          i;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  strb;
		logic [7:0]  idx;
		resetn = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		req_strb = '0;
		repeat (2) @(posedge clk_50mhz);
		@(negedge clk_50mhz);
		check_reset_outputs();
		resetn = 1'b1;
		for (i = 0; i < periph_pkg::boot_depth; i++) begin
			wdata = take_bits(32);
			model_mem[i] = wdata;
			addr = periph_pkg::boot_base | (32'(i) << 2);
			send(1'b1, addr, wdata, 4'hF, '0, bus_pkg::resp_okay, 1'b0);
		end
		// Partial writes through aliased addresses
		for (i = 0; i < mix_count; i++) begin
			idx = 8'(take_bits(8));
			addr = periph_pkg::boot_base | (take_bits(6) << 10) | {22'd0, idx, 2'b00};
			wdata = take_bits(32);
			strb = 4'(take_bits(4));
			ram_used.push_back(idx);
			model_mem[idx] = merge_bytes(model_mem[idx], wdata, strb);
			send(1'b1, addr, wdata, strb, '0, bus_pkg::resp_okay, 1'b0);
		end
		for (i = 0; i < mix_count; i++) begin
			idx = ram_used[i];
			addr = periph_pkg::boot_base | (take_bits(6) << 10) | {22'd0, idx, 2'b00};
			send(1'b0, addr, '0, '0, model_mem[idx], bus_pkg::resp_okay, 1'b0);
		end
		send(1'b0, 32'h0300_0000, '0, '0, '0, bus_pkg::resp_decerr, 1'b0);
		send(1'b1, 32'h0200_0100, take_bits(32), 4'hF, '0, bus_pkg::resp_decerr, 1'b0);
		send(1'b1, periph_pkg::cnt_base, '1, 4'hF, '0, bus_pkg::resp_slverr, 1'b0);
		send(1'b1, periph_pkg::pad_base, '1, 4'hF, '0, bus_pkg::resp_slverr, 1'b0);
		for (i = 0; i < cnt_reads; i++)
			send(1'b0, periph_pkg::cnt_base, '0, '0, '0, bus_pkg::resp_okay, 1'b1);
		send(1'b0, periph_pkg::cnt_base + 32'd4, '0, '0, '0, bus_pkg::resp_okay, 1'b0);
		pad0_buttons = 8'(take_bits(8));
		pad1_buttons = 8'(take_bits(8));
		// First latch loads the pattern and the second ends its scan
		repeat (2) @(posedge pad_latch);
		@(negedge clk_50mhz);
		send(1'b0, periph_pkg::pad_base, '0, '0, {16'd0, pad1_buttons, pad0_buttons},
			bus_pkg::resp_okay, 1'b0);
		while (exp_resp.size() != 0)
			@(negedge clk_50mhz);
		repeat (4) @(negedge clk_50mhz);
		$display("Errors: %0d in bench checks, %0d in bound assertions", errors,
			soc_bus_top_i.target_router_i.props_i.fail_count);
		if (errors == 0 && soc_bus_top_i.target_router_i.props_i.fail_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial begin
		#(limit_cycles * clk_period);
		$display("Timeout after %0d cycles with %0d responses outstanding",
			limit_cycles, exp_resp.size());
		$display("Verification failed");
		$finish;
	end

endmodule

// ==== soc_bus_props.sv ====
// Router handshake assertions
`timescale 1ns/100ps

module soc_bus_props (
	input logic              clk_50mhz,
	input logic              resetn,
	input logic              req_valid,
	input logic              req_ready,
	input bus_pkg::bus_req_t req_data,
	input logic              rsp_valid,
	input logic              rsp_ready,
	input bus_pkg::bus_rsp_t rsp_data
);

	int unsigned fail_count = 0;

	// Slice output holds while the router stalls
	req_hold: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		req_valid && !req_ready |=> req_valid && $stable(req_data))
		else begin
			fail_count++;
			$error("request payload changed while stalled");
		end

	rsp_hold: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
		else begin
			fail_count++;
			$error("response payload changed while stalled");
		end

	rsp_after_reset: assert property (@(posedge clk_50mhz) !resetn |=> !rsp_valid)
		else begin
			fail_count++;
			$error("rsp_valid high right after reset");
		end

endmodule

bind target_router soc_bus_props props_i (
	.clk_50mhz(clk_50mhz), .resetn(resetn),
	.req_valid(req_valid), .req_ready(req_ready), .req_data(req_data),
	.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data)
);

// ==== soc_bus_top.sv ====
// Bus fabric top level
`timescale 1ns/100ps

module soc_bus_top (
	input  logic                       clk_50mhz,
	input  logic                       resetn,
	input  logic                       req_valid,
	output logic                       req_ready,
	input  logic                       req_write,
	input  logic [bus_pkg::addr_w-1:0] req_addr,
	input  logic [bus_pkg::data_w-1:0] req_wdata,
	input  logic [bus_pkg::strb_w-1:0] req_strb,
	output logic                       rsp_valid,
	input  logic                       rsp_ready,
	output logic [bus_pkg::data_w-1:0] rsp_rdata,
	output logic [1:0]                 rsp_resp,
	output logic                       pad_clk,
	output logic                       pad_latch,
	input  logic                       pad0_data,
	input  logic                       pad1_data
);

	bus_pkg::bus_req_t                   req_in;
	bus_pkg::bus_req_t                   s_req_data;
	logic                                s_req_valid;
	logic                                s_req_ready;
	bus_pkg::bus_rsp_t                   r_rsp_data;
	logic                                r_rsp_valid;
	logic                                r_rsp_ready;
	bus_pkg::bus_rsp_t                   rsp_out;
	logic                                ram_en;
	logic                                ram_we;
	logic [periph_pkg::boot_index_w-1:0] ram_index;
	logic [bus_pkg::data_w-1:0]          ram_wdata;
	logic [bus_pkg::strb_w-1:0]          ram_strb;
	logic [bus_pkg::data_w-1:0]          ram_rdata;
	logic                                cnt_rd;
	logic                                cnt_word;
	logic [bus_pkg::data_w-1:0]          cnt_rdata;
	logic                                pad_rd;
	logic [bus_pkg::data_w-1:0]          pad_rdata;

	assign req_in = '{write: req_write, addr: req_addr, wdata: req_wdata, strb: req_strb};
	assign rsp_rdata = rsp_out.rdata;
	assign rsp_resp = rsp_out.resp;

	bus_slice #(.payload_t(bus_pkg::bus_req_t)) req_slice_i (
		.clk_50mhz(clk_50mhz), .resetn(resetn),
		.in_valid(req_valid), .in_ready(req_ready), .in_data(req_in),
		.out_valid(s_req_valid), .out_ready(s_req_ready), .out_data(s_req_data)
	);

	target_router target_router_i (
		.clk_50mhz(clk_50mhz), .resetn(resetn),
		.req_valid(s_req_valid), .req_ready(s_req_ready), .req_data(s_req_data),
		.rsp_valid(r_rsp_valid), .rsp_ready(r_rsp_ready), .rsp_data(r_rsp_data),
		.ram_en(ram_en), .ram_we(ram_we), .ram_index(ram_index),
		.ram_wdata(ram_wdata), .ram_strb(ram_strb), .ram_rdata(ram_rdata),
		.cnt_rd(cnt_rd), .cnt_word(cnt_word), .cnt_rdata(cnt_rdata),
		.pad_rd(pad_rd), .pad_rdata(pad_rdata)
	);

	bus_slice #(.payload_t(bus_pkg::bus_rsp_t)) rsp_slice_i (
		.clk_50mhz(clk_50mhz), .resetn(resetn),
		.in_valid(r_rsp_valid), .in_ready(r_rsp_ready), .in_data(r_rsp_data),
		.out_valid(rsp_valid), .out_ready(rsp_ready), .out_data(rsp_out)
	);

	boot_ram boot_ram_i (
		.clk_50mhz(clk_50mhz), .ram_en(ram_en), .ram_we(ram_we),
		.ram_index(ram_index), .ram_wdata(ram_wdata), .ram_strb(ram_strb),
		.ram_rdata(ram_rdata)
	);

	cycle_counter cycle_counter_i (
		.clk_50mhz(clk_50mhz), .resetn(resetn),
		.cnt_rd(cnt_rd), .cnt_word(cnt_word), .cnt_rdata(cnt_rdata)
	);

	pad_reader pad_reader_i (
		.clk_50mhz(clk_50mhz), .resetn(resetn),
		.pad_clk(pad_clk), .pad_latch(pad_latch),
		.pad0_data(pad0_data), .pad1_data(pad1_data),
		.pad_rd(pad_rd), .pad_rdata(pad_rdata)
	);

endmodule

// ==== pad_reader.sv ====
// Serial game pad reader
`timescale 1ns/100ps

module pad_reader (
	input  logic                       clk_50mhz,
	input  logic                       resetn,
	output logic                       pad_clk,
	output logic                       pad_latch,
	input  logic                       pad0_data,
	input  logic                       pad1_data,
	input  logic                       pad_rd,
	output logic [bus_pkg::data_w-1:0] pad_rdata
);

	logic [periph_pkg::pad_div_bits-1:0] div;
	logic                                tick;
	logic [4:0]                          step;
	logic [4:0]                          step_next;
	logic                                scan_done;
	logic                                clk_phase;
	logic [periph_pkg::pad_buttons-1:0]  shift0;
	logic [periph_pkg::pad_buttons-1:0]  shift1;
	logic [periph_pkg::pad_buttons-1:0]  btn0;
	logic [periph_pkg::pad_buttons-1:0]  btn1;

	assign tick = &div;

	// Latch on step 0 then clock high on odd steps and low on even ones
	assign scan_done = step == 5'(2 * periph_pkg::pad_buttons + 1);
	assign step_next = scan_done ? 5'd0 : step + 5'd1;
	assign clk_phase = step_next[0] && (step_next != 5'(2 * periph_pkg::pad_buttons + 1));

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			div <= '0;
			step <= 5'(2 * periph_pkg::pad_buttons + 1);
			pad_latch <= 1'b0;
			pad_clk <= 1'b0;
			btn0 <= '0;
			btn1 <= '0;
		end else begin
			div <= div + 1'b1;
			if (tick) begin
				step <= step_next;
				pad_latch <= step_next == 5'd0;
				pad_clk <= clk_phase;
				if (scan_done) begin
					btn0 <= shift0;
					btn1 <= shift1;
				end
			end
		end
	end

	// Sample just before the clock rises so the first bit lands in bit 0
	always_ff @(posedge clk_50mhz) begin
		if (tick && clk_phase) begin
			shift0 <= {~pad0_data, shift0[periph_pkg::pad_buttons-1:1]};
			shift1 <= {~pad1_data, shift1[periph_pkg::pad_buttons-1:1]};
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (pad_rd)
			pad_rdata <= {{(bus_pkg::data_w - 2 * periph_pkg::pad_buttons){1'b0}}, btn1, btn0};
	end

endmodule

// ==== cycle_counter.sv ====
// Free-running 64-bit cycle counter
`timescale 1ns/100ps

module cycle_counter (
	input  logic                       clk_50mhz,
	input  logic                       resetn,
	input  logic                       cnt_rd,
	input  logic                       cnt_word,
	output logic [bus_pkg::data_w-1:0] cnt_rdata
);

	logic [63:0] count;
	logic [31:0] high_shadow;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			count <= 64'd0;
			high_shadow <= 32'd0;
		end else begin
			count <= count + 64'd1;
			// Low word read freezes the matching high half
			if (cnt_rd && !cnt_word)
				high_shadow <= count[63:32];
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (cnt_rd)
			cnt_rdata <= cnt_word ? high_shadow : count[31:0];
	end

endmodule

// ==== boot_ram.sv ====
// Boot memory with byte strobes
`timescale 1ns/100ps

module boot_ram (
	input  logic                                clk_50mhz,
	input  logic                                ram_en,
	input  logic                                ram_we,
	input  logic [periph_pkg::boot_index_w-1:0] ram_index,
	input  logic [bus_pkg::data_w-1:0]          ram_wdata,
	input  logic [bus_pkg::strb_w-1:0]          ram_strb,
	output logic [bus_pkg::data_w-1:0]          ram_rdata
);

	logic [bus_pkg::data_w-1:0] mem [periph_pkg::boot_depth];

	// Read returns the word as it was before a same-cycle write
	always_ff @(posedge clk_50mhz) begin
		if (ram_en) begin
			if (ram_we) begin
				for (int b = 0; b < bus_pkg::strb_w; b++) begin
					if (ram_strb[b])
						mem[ram_index][b*8 +: 8] <= ram_wdata[b*8 +: 8];
				end
			end
			ram_rdata <= mem[ram_index];
		end
	end

endmodule

// ==== target_router.sv ====
// Address decode and target routing
`timescale 1ns/100ps

module target_router (
	input  logic                                clk_50mhz,
	input  logic                                resetn,
	input  logic                                req_valid,
	output logic                                req_ready,
	input  bus_pkg::bus_req_t                   req_data,
	output logic                                rsp_valid,
	input  logic                                rsp_ready,
	output bus_pkg::bus_rsp_t                   rsp_data,
	output logic                                ram_en,
	output logic                                ram_we,
	output logic [periph_pkg::boot_index_w-1:0] ram_index,
	output logic [bus_pkg::data_w-1:0]          ram_wdata,
	output logic [bus_pkg::strb_w-1:0]          ram_strb,
	input  logic [bus_pkg::data_w-1:0]          ram_rdata,
	output logic                                cnt_rd,
	output logic                                cnt_word,
	input  logic [bus_pkg::data_w-1:0]          cnt_rdata,
	output logic                                pad_rd,
	input  logic [bus_pkg::data_w-1:0]          pad_rdata
);

	logic                       req_fire;
	logic                       hit_boot;
	logic                       hit_pad;
	logic                       hit_cnt;
	logic [1:0]                 dec_resp;
	logic                       iss_valid;
	logic                       iss_ram;
	logic                       iss_cnt;
	logic                       iss_pad;
	logic [1:0]                 iss_resp;
	logic                       cap_load;
	logic [bus_pkg::data_w-1:0] cap_rdata;

	// Region match on the upper address bits
	assign hit_boot = req_data.addr[bus_pkg::addr_w-1:periph_pkg::boot_region_bits] ==
		periph_pkg::boot_base[bus_pkg::addr_w-1:periph_pkg::boot_region_bits];
	assign hit_pad = req_data.addr[bus_pkg::addr_w-1:periph_pkg::pad_region_bits] ==
		periph_pkg::pad_base[bus_pkg::addr_w-1:periph_pkg::pad_region_bits];
	assign hit_cnt = req_data.addr[bus_pkg::addr_w-1:periph_pkg::cnt_region_bits] ==
		periph_pkg::cnt_base[bus_pkg::addr_w-1:periph_pkg::cnt_region_bits];

	always_comb begin
		if (hit_boot)
			dec_resp = bus_pkg::resp_okay;
		else if (hit_cnt || hit_pad)
			dec_resp = req_data.write ? bus_pkg::resp_slverr : bus_pkg::resp_okay;
		else
			dec_resp = bus_pkg::resp_decerr;
	end

	// Issue stage moves only when the pending item can be captured
	assign cap_load = iss_valid && (!rsp_valid || rsp_ready);
	assign req_ready = !iss_valid || cap_load;
	assign req_fire = req_valid && req_ready;

	// Target strobes
	assign ram_en = req_fire && hit_boot;
	assign ram_we = req_data.write;
	assign ram_index = req_data.addr[periph_pkg::boot_index_w+1:2];
	assign ram_wdata = req_data.wdata;
	assign ram_strb = req_data.strb;
	assign cnt_rd = req_fire && hit_cnt && !req_data.write;
	assign cnt_word = req_data.addr[2];
	assign pad_rd = req_fire && hit_pad && !req_data.write;

	// Read data is zero for writes and errors
	always_comb begin
		if (iss_ram)
			cap_rdata = ram_rdata;
		else if (iss_cnt)
			cap_rdata = cnt_rdata;
		else if (iss_pad)
			cap_rdata = pad_rdata;
		else
			cap_rdata = '0;
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			iss_valid <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			if (req_ready)
				iss_valid <= req_valid;
			if (cap_load)
				rsp_valid <= 1'b1;
			else if (rsp_ready)
				rsp_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (req_fire) begin
			iss_ram <= hit_boot && !req_data.write;
			iss_cnt <= cnt_rd;
			iss_pad <= pad_rd;
			iss_resp <= dec_resp;
		end
		if (cap_load) begin
			rsp_data.rdata <= cap_rdata;
			rsp_data.resp <= iss_resp;
		end
	end

endmodule

// ==== bus_slice.sv ====
// Valid/ready skid buffer
`timescale 1ns/100ps

module bus_slice #(
	parameter type payload_t = logic
) (
	input  logic     clk_50mhz,
	input  logic     resetn,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic     in_fire;
	logic     skid_valid;
	logic     skid_next;
	logic     out_valid_next;
	payload_t skid_data;

	assign in_fire = in_valid && in_ready;

	// Output register loads when free, otherwise the item parks in the skid entry
	always_comb begin
		out_valid_next = out_valid;
		skid_next = skid_valid;
		if (!out_valid || out_ready) begin
			out_valid_next = skid_valid || in_fire;
			skid_next = 1'b0;
		end else if (in_fire) begin
			skid_next = 1'b1;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			out_valid <= 1'b0;
			skid_valid <= 1'b0;
			in_ready <= 1'b0;
		end else begin
			out_valid <= out_valid_next;
			skid_valid <= skid_next;
			in_ready <= !skid_next;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (!out_valid || out_ready)
			out_data <= skid_valid ? skid_data : in_data;
		if (in_fire && out_valid && !out_ready)
			skid_data <= in_data;
	end

endmodule

// ==== periph_pkg.sv ====
// Peripheral address map
package periph_pkg;

	// Boot memory, 64 KiB window
	localparam logic [bus_pkg::addr_w-1:0] boot_base = 32'h0201_0000;
	localparam int boot_region_bits = 16;

	// Game pad reader
	localparam logic [bus_pkg::addr_w-1:0] pad_base = 32'h0200_0200;
	localparam int pad_region_bits = 2;

	// Cycle counter, low word at +0 and high word at +4
	localparam logic [bus_pkg::addr_w-1:0] cnt_base = 32'h0200_0300;
	localparam int cnt_region_bits = 3;

	// Boot memory sizing, aliased inside its window
	localparam int boot_depth   = 256;
	localparam int boot_index_w = 8;

	// Pad tick every 512 clocks
	localparam int pad_div_bits = 9;
	localparam int pad_buttons  = 8;

endpackage

// ==== bus_pkg.sv ====
// Bus transport definitions
package bus_pkg;

	// Transport widths
	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int strb_w = 4;

	// Response codes
	localparam logic [1:0] resp_okay   = 2'd0;
	localparam logic [1:0] resp_slverr = 2'd2;
	localparam logic [1:0] resp_decerr = 2'd3;

	// Request record, 69 bits
	typedef struct packed {
		logic              write;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata;
		logic [strb_w-1:0] strb;
	} bus_req_t;

	// Response record, 34 bits
	typedef struct packed {
		logic [data_w-1:0] rdata;
		logic [1:0]        resp;
	} bus_rsp_t;

endpackage
